// ==== hdl/EventLogPkg.sv ====
package EventLogPkg;

  // Timestamp occupies word 0 of every entry
  localparam int TIMESTAMP_BITS = 32;

  // Register bus widths
  localparam int BUS_BITS      = 32;
  localparam int REG_ADDR_BITS = 16;

  // Address bit that switches to the log window
  localparam int LOG_WINDOW_BIT = 15;

  // Register word addresses
  // CTRL: bit 0 enable (rw), bit 1 clear (wo, reads 0)
  localparam logic [REG_ADDR_BITS-1:0] REG_CTRL   = 16'd0;
  // STATUS is read-only
  localparam logic [REG_ADDR_BITS-1:0] REG_STATUS = 16'd1;
  // Number of stored entries, read-only
  localparam logic [REG_ADDR_BITS-1:0] REG_COUNT  = 16'd2;
  // Almost-full margin in entries
  localparam logic [REG_ADDR_BITS-1:0] REG_MARGIN = 16'd3;

  // Status bit positions
  localparam int STAT_READY       = 0;
  localparam int STAT_FULL        = 1;
  localparam int STAT_ALMOST_FULL = 2;

  // Margin after reset
  localparam logic [BUS_BITS-1:0] MARGIN_RESET = 32'd4;

endpackage

// ==== hdl/LogRam.sv ====
`timescale 1ns/1ps

module LogRam #(
  parameter  int LOG_DATA_BITS = 96,
  parameter  int NUM_ENTRIES   = 16,
  localparam int ENTRY_BITS    = LOG_DATA_BITS + EventLogPkg::TIMESTAMP_BITS,
  localparam int IDX_BITS      = $clog2(NUM_ENTRIES)
) (
  input  logic                  Clk_CI,
  // Write port from the controller
  input  logic                  ramWrEn,
  input  logic [IDX_BITS-1:0]   ramWrIdx,
  input  logic [ENTRY_BITS-1:0] ramWrData,
  // Read port toward the word reader
  input  logic                  ramRdEn,
  input  logic [IDX_BITS-1:0]   ramRdIdx,
  output logic [ENTRY_BITS-1:0] ramRdData
);

  // One full entry per location
  logic [ENTRY_BITS-1:0] mem [NUM_ENTRIES];

  always_ff @(posedge Clk_CI) begin
    if (ramWrEn) begin
      mem[ramWrIdx] <= ramWrData;
    end
  end

  // Registered read, old data on same-address collision
  always_ff @(posedge Clk_CI) begin
    if (ramRdEn) begin
      ramRdData <= mem[ramRdIdx];
    end
  end

endmodule

// ==== hdl/LogWordReader.sv ====
`timescale 1ns/1ps

module LogWordReader #(
  parameter  int LOG_DATA_BITS  = 96,
  parameter  int NUM_ENTRIES    = 16,
  localparam int ENTRY_BITS     = LOG_DATA_BITS + EventLogPkg::TIMESTAMP_BITS,
  localparam int WORDS          = ENTRY_BITS / EventLogPkg::BUS_BITS,
  localparam int IDX_BITS       = $clog2(NUM_ENTRIES),
  localparam int SEL_BITS       = $clog2(WORDS),
  localparam int WORD_ADDR_BITS = IDX_BITS + SEL_BITS
) (
  input  logic                             Clk_CI,
  input  logic                             rstN,
  input  logic                             wordRdEn,
  input  logic [WORD_ADDR_BITS-1:0]        wordAddr,
  output logic                             ramRdEn,
  output logic [IDX_BITS-1:0]              ramRdIdx,
  input  logic [ENTRY_BITS-1:0]            ramRdData,
  output logic [EventLogPkg::BUS_BITS-1:0] wordData,
  output logic                             wordValid
);

  logic                                        validQ;
  logic [SEL_BITS-1:0]                         selQ;
  logic [WORDS-1:0][EventLogPkg::BUS_BITS-1:0] entryWords;

  // Entry index from upper bits
  assign ramRdEn  = wordRdEn;
  assign ramRdIdx = wordAddr[WORD_ADDR_BITS-1:SEL_BITS];

  // Entry viewed as an array of bus words
  assign entryWords = ramRdData;

  // Valid follows the RAM latency
  always_ff @(posedge Clk_CI) begin
    if (!rstN) begin
      validQ    <= 1'b0;
      wordValid <= 1'b0;
    end else begin
      validQ    <= wordRdEn;
      wordValid <= validQ;
    end
  end

  // Word select aligned with RAM output
  always_ff @(posedge Clk_CI) begin
    selQ <= wordAddr[SEL_BITS-1:0];
    if (validQ) begin
      wordData <= entryWords[selQ];
    end
  end

endmodule

// ==== hdl/LogCtrl.sv ====
`timescale 1ns/1ps

module LogCtrl #(
  parameter  int LOG_DATA_BITS = 96,
  parameter  int NUM_ENTRIES   = 16,
  localparam int ENTRY_BITS    = LOG_DATA_BITS + EventLogPkg::TIMESTAMP_BITS,
  localparam int IDX_BITS      = $clog2(NUM_ENTRIES)
) (
  input  logic                             Clk_CI,
  input  logic                             rstN,
  input  logic [LOG_DATA_BITS-1:0]         logData,
  input  logic                             logTrigger,
  input  logic                             logEnable,
  input  logic                             clearCmd,
  input  logic [EventLogPkg::BUS_BITS-1:0] margin,
  output logic                             ramWrEn,
  output logic [IDX_BITS-1:0]              ramWrIdx,
  output logic [ENTRY_BITS-1:0]            ramWrData,
  output logic [IDX_BITS:0]                entryCount,
  output logic                             full,
  output logic                             ready,
  output logic                             almostFull
);

  localparam logic [IDX_BITS-1:0] LAST_IDX   = IDX_BITS'(NUM_ENTRIES - 1);
  localparam logic [IDX_BITS:0]   LAST_COUNT = (IDX_BITS + 1)'(NUM_ENTRIES - 1);
  localparam logic [IDX_BITS:0]   FULL_COUNT = (IDX_BITS + 1)'(NUM_ENTRIES);

  typedef enum logic [1:0] {
    StReady,
    StClearing,
    StFull
  } stateT;

  stateT                                 stateQ, stateD;
  logic [IDX_BITS-1:0]                   wrPtrQ, wrPtrD;
  logic [IDX_BITS:0]                     countD;
  logic [EventLogPkg::TIMESTAMP_BITS-1:0] timestamp;
  logic [EventLogPkg::BUS_BITS:0]        fillSum;

  // Free-running timestamp, wraps on overflow
  always_ff @(posedge Clk_CI) begin
    if (!rstN) begin
      timestamp <= '0;
    end else begin
      timestamp <= timestamp + 1'b1;
    end
  end

  // Next state, pointer and count
  always_comb begin
    stateD  = stateQ;
    wrPtrD  = wrPtrQ;
    countD  = entryCount;
    ramWrEn = 1'b0;
    case (stateQ)
      StReady: begin
        if (clearCmd) begin
          stateD = StClearing;
          wrPtrD = '0;
          countD = '0;
        end else if (logTrigger && logEnable) begin
          ramWrEn = 1'b1;
          wrPtrD  = wrPtrQ + 1'b1;
          countD  = entryCount + 1'b1;
          // Last free slot taken
          if (entryCount == LAST_COUNT) begin
            stateD = StFull;
          end
        end
      end
      StClearing: begin
        // Sweep writes zeros to every entry
        ramWrEn = 1'b1;
        wrPtrD  = wrPtrQ + 1'b1;
        if (wrPtrQ == LAST_IDX) begin
          stateD = StReady;
        end
      end
      StFull: begin
        if (clearCmd) begin
          stateD = StClearing;
          wrPtrD = '0;
          countD = '0;
        end
      end
      default: stateD = StReady;
    endcase
  end

  always_ff @(posedge Clk_CI) begin
    if (!rstN) begin
      stateQ     <= StReady;
      wrPtrQ     <= '0;
      entryCount <= '0;
    end else begin
      stateQ     <= stateD;
      wrPtrQ     <= wrPtrD;
      entryCount <= countD;
    end
  end

  // Entry layout: timestamp in word 0, payload above
  assign ramWrIdx  = wrPtrQ;
  assign ramWrData = (stateQ == StClearing) ? '0 : {logData, timestamp};

  // Status, margin compare without underflow
  assign ready      = (stateQ == StReady);
  assign full       = (entryCount == FULL_COUNT);
  assign fillSum    = (EventLogPkg::BUS_BITS + 1)'(entryCount) + {1'b0, margin};
  assign almostFull = (fillSum >= (EventLogPkg::BUS_BITS + 1)'(NUM_ENTRIES));

endmodule

// ==== hdl/LogRegs.sv ====
`timescale 1ns/1ps

module LogRegs #(
  parameter  int LOG_DATA_BITS  = 96,
  parameter  int NUM_ENTRIES    = 16,
  localparam int ENTRY_BITS     = LOG_DATA_BITS + EventLogPkg::TIMESTAMP_BITS,
  localparam int WORDS          = ENTRY_BITS / EventLogPkg::BUS_BITS,
  localparam int IDX_BITS       = $clog2(NUM_ENTRIES),
  localparam int SEL_BITS       = $clog2(WORDS),
  localparam int WORD_ADDR_BITS = IDX_BITS + SEL_BITS
) (
  input  logic                                  Clk_CI,
  input  logic                                  rstN,
  input  logic [EventLogPkg::REG_ADDR_BITS-1:0] regAddr,
  input  logic                                  regWrEn,
  input  logic [EventLogPkg::BUS_BITS-1:0]      regWrData,
  input  logic                                  regRdEn,
  input  logic [IDX_BITS:0]                     entryCount,
  input  logic                                  full,
  input  logic                                  ready,
  input  logic                                  almostFull,
  input  logic [EventLogPkg::BUS_BITS-1:0]      wordData,
  input  logic                                  wordValid,
  output logic [EventLogPkg::BUS_BITS-1:0]      regRdData,
  output logic                                  regRdValid,
  output logic                                  logEnable,
  output logic                                  clearCmd,
  output logic [EventLogPkg::BUS_BITS-1:0]      margin,
  output logic                                  wordRdEn,
  output logic [WORD_ADDR_BITS-1:0]             wordAddr
);

  // CTRL bit positions
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_CLEAR_BIT  = 1;

  logic                             ctrlWrite;
  logic                             marginWrite;
  logic                             regRead;
  logic [EventLogPkg::BUS_BITS-1:0] regMux;

  // Address decode, window addresses never match a register
  assign ctrlWrite   = regWrEn && (regAddr == EventLogPkg::REG_CTRL);
  assign marginWrite = regWrEn && (regAddr == EventLogPkg::REG_MARGIN);
  assign regRead     = regRdEn && !regAddr[EventLogPkg::LOG_WINDOW_BIT];

  // Log-window read goes straight to the word reader
  assign wordRdEn = regRdEn && regAddr[EventLogPkg::LOG_WINDOW_BIT];
  assign wordAddr = regAddr[WORD_ADDR_BITS-1:0];

  // Register read mux
  always_comb begin
    regMux = '0;
    case (regAddr)
      EventLogPkg::REG_CTRL: regMux[CTRL_ENABLE_BIT] = logEnable;
      EventLogPkg::REG_STATUS: begin
        regMux[EventLogPkg::STAT_READY]       = ready;
        regMux[EventLogPkg::STAT_FULL]        = full;
        regMux[EventLogPkg::STAT_ALMOST_FULL] = almostFull;
      end
      EventLogPkg::REG_COUNT:  regMux = EventLogPkg::BUS_BITS'(entryCount);
      EventLogPkg::REG_MARGIN: regMux = margin;
      default: regMux = '0;
    endcase
  end

  // Control registers and read valid
  always_ff @(posedge Clk_CI) begin
    if (!rstN) begin
      logEnable  <= 1'b0;
      clearCmd   <= 1'b0;
      margin     <= EventLogPkg::MARGIN_RESET;
      regRdValid <= 1'b0;
    end else begin
      // Clear bit becomes a single-cycle pulse
      clearCmd   <= ctrlWrite && regWrData[CTRL_CLEAR_BIT];
      regRdValid <= regRead || wordValid;
      if (ctrlWrite) begin
        logEnable <= regWrData[CTRL_ENABLE_BIT];
      end
      if (marginWrite) begin
        margin <= regWrData;
      end
    end
  end

  // Read data, log word has priority on collision
  always_ff @(posedge Clk_CI) begin
    if (wordValid) begin
      regRdData <= wordData;
    end else if (regRead) begin
      regRdData <= regMux;
    end
  end

endmodule

// ==== hdl/EventLogTop.sv ====
`timescale 1ns/1ps

module EventLogTop #(
  parameter  int LOG_DATA_BITS  = 96,
  parameter  int NUM_ENTRIES    = 16,
  localparam int ENTRY_BITS     = LOG_DATA_BITS + EventLogPkg::TIMESTAMP_BITS,
  localparam int WORDS          = ENTRY_BITS / EventLogPkg::BUS_BITS,
  localparam int IDX_BITS       = $clog2(NUM_ENTRIES),
  localparam int WORD_ADDR_BITS = IDX_BITS + $clog2(WORDS)
) (
  input  logic                                  Clk_CI,
  input  logic                                  rstN,
  input  logic [LOG_DATA_BITS-1:0]              logData,
  input  logic                                  logTrigger,
  input  logic [EventLogPkg::REG_ADDR_BITS-1:0] regAddr,
  input  logic                                  regWrEn,
  input  logic [EventLogPkg::BUS_BITS-1:0]      regWrData,
  input  logic                                  regRdEn,
  output logic [EventLogPkg::BUS_BITS-1:0]      regRdData,
  output logic                                  regRdValid,
  output logic                                  ready,
  output logic                                  almostFull
);

  // Registers to controller
  logic                             logEnable;
  logic                             clearCmd;
  logic [EventLogPkg::BUS_BITS-1:0] margin;
  // Controller status back
  logic [IDX_BITS:0]                entryCount;
  logic                             full;
  // RAM write and read ports
  logic                             ramWrEn;
  logic [IDX_BITS-1:0]              ramWrIdx;
  logic [ENTRY_BITS-1:0]            ramWrData;
  logic                             ramRdEn;
  logic [IDX_BITS-1:0]              ramRdIdx;
  logic [ENTRY_BITS-1:0]            ramRdData;
  // Log window path
  logic                             wordRdEn;
  logic [WORD_ADDR_BITS-1:0]        wordAddr;
  logic [EventLogPkg::BUS_BITS-1:0] wordData;
  logic                             wordValid;

  LogRegs #(.LOG_DATA_BITS(LOG_DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) LogRegs_inst (.*);

  LogCtrl #(.LOG_DATA_BITS(LOG_DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) LogCtrl_inst (.*);

  LogRam #(.LOG_DATA_BITS(LOG_DATA_BITS), .NUM_ENTRIES(NUM_ENTRIES)) LogRam_inst (.*);

  LogWordReader #(
    .LOG_DATA_BITS(LOG_DATA_BITS),
    .NUM_ENTRIES  (NUM_ENTRIES)
  ) LogWordReader_inst (.*);

endmodule

// ==== test/EventLogTb.sv ====
`timescale 1ns/1ps

module EventLogTb;

  localparam int LOG_DATA_BITS = 96;
  localparam int NUM_ENTRIES   = 16;
  localparam int WORDS         = (LOG_DATA_BITS + EventLogPkg::TIMESTAMP_BITS) / 32;
  localparam int SEL_BITS      = $clog2(WORDS);
  localparam int IDX_BITS      = $clog2(NUM_ENTRIES);

  // Step kinds of the stimulus table
  localparam logic [2:0] K_IDLE = 3'd0;
  localparam logic [2:0] K_TRIG = 3'd1;
  localparam logic [2:0] K_WR   = 3'd2;
  localparam logic [2:0] K_RD   = 3'd3;
  localparam logic [2:0] K_LOG  = 3'd4;

  // Kinds of reads in flight
  localparam logic [1:0] R_REG    = 2'd0;
  localparam logic [1:0] R_STATUS = 2'd1;
  localparam logic [1:0] R_LOG    = 2'd2;

  // One table row with write data or expected register value in val
  typedef struct packed {
    logic [2:0]  kind;
    logic [15:0] addr;
    logic [31:0] val;
  } stepT;

  // Outstanding read with pin snapshot at issue time
  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] exp;
    logic [31:0] issued;
    logic        rdy;
    logic        af;
  } readT;

  logic                                  Clk_CI;
  logic                                  rstN;
  logic [LOG_DATA_BITS-1:0]              logData;
  logic                                  logTrigger;
  logic [EventLogPkg::REG_ADDR_BITS-1:0] regAddr;
  logic                                  regWrEn;
  logic [EventLogPkg::BUS_BITS-1:0]      regWrData;
  logic                                  regRdEn;
  logic [EventLogPkg::BUS_BITS-1:0]      regRdData;
  logic                                  regRdValid;
  logic                                  ready;
  logic                                  almostFull;

  stepT        steps[$];
  readT        pending[$];
  logic [31:0] cycle;
  logic [31:0] rngState;
  // Reference log contents with the timestamp in word 0
  logic [31:0] modelMem [NUM_ENTRIES][WORDS];
  int          modelCount;
  logic        modelEnable;

  EventLogTop #(
    .LOG_DATA_BITS(LOG_DATA_BITS),
    .NUM_ENTRIES  (NUM_ENTRIES)
  ) EventLogTop_inst (
    .Clk_CI    (Clk_CI),
    .rstN      (rstN),
    .logData   (logData),
    .logTrigger(logTrigger),
    .regAddr   (regAddr),
    .regWrEn   (regWrEn),
    .regWrData (regWrData),
    .regRdEn   (regRdEn),
    .regRdData (regRdData),
    .regRdValid(regRdValid),
    .ready     (ready),
    .almostFull(almostFull)
  );

  always #20 Clk_CI = ~Clk_CI;

  // Edges since reset release track the DUT timestamp
  always @(posedge Clk_CI) begin
    if (!rstN) begin
      cycle <= '0;
    end else begin
      cycle <= cycle + 1'b1;
    end
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkWord(input string what, input logic [EventLogPkg::BUS_BITS-1:0] got,
                           input logic [EventLogPkg::BUS_BITS-1:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("** Error at %0t: %s expected %h got %h", $time, what, exp, got));
    end
  endtask

  // Status word against table value and against the status pins
  task automatic checkStatus(input logic [EventLogPkg::BUS_BITS-1:0] got,
                             input logic [EventLogPkg::BUS_BITS-1:0] exp,
                             input logic rdyPin, input logic afPin);
    if (got !== exp || got[EventLogPkg::STAT_READY] !== rdyPin ||
        got[EventLogPkg::STAT_ALMOST_FULL] !== afPin) begin
      abortRun($sformatf("** Error at %0t: STATUS expected %h got %h, pins ready %b almostFull %b",
                         $time, exp, got, rdyPin, afPin));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] statusWord(input logic rdy, input logic fl, input logic af);
    logic [31:0] w;
    w = '0;
    w[EventLogPkg::STAT_READY]       = rdy;
    w[EventLogPkg::STAT_FULL]        = fl;
    w[EventLogPkg::STAT_ALMOST_FULL] = af;
    return w;
  endfunction

  // Window address of one word of one entry
  function automatic logic [15:0] logAddr(input int entry, input int word);
    logic [15:0] a;
    a = 16'(entry * WORDS + word);
    a[EventLogPkg::LOG_WINDOW_BIT] = 1'b1;
    return a;
  endfunction

  task automatic addStep(input logic [2:0] kind, input logic [15:0] addr, input logic [31:0] val);
    steps.push_back(stepT'({kind, addr, val}));
  endtask

  function automatic bit logReadsPending();
    foreach (pending[i]) begin
      if (pending[i].kind == R_LOG) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Oldest read must return exactly at its latency
  task automatic checkResponse();
    readT        rec;
    logic [31:0] lat;
    if (pending.size() != 0) begin
      rec = pending[0];
      lat = (rec.kind == R_LOG) ? 32'd3 : 32'd1;
      if (regRdValid && (cycle - rec.issued != lat)) begin
        abortRun($sformatf("Read result came %0d cycles after the strobe instead of %0d",
                           cycle - rec.issued, lat));
      end else if (!regRdValid && (cycle - rec.issued >= lat)) begin
        abortRun("Read result missing, no valid pulse in the expected cycle");
      end else if (regRdValid) begin
        void'(pending.pop_front());
        if (rec.kind == R_STATUS) begin
          checkStatus(regRdData, rec.exp, rec.rdy, rec.af);
        end else begin
          checkWord("read data", regRdData, rec.exp);
        end
      end
    end else if (regRdValid) begin
      abortRun("Read valid pulse seen with no read outstanding");
    end
  endtask

  // Check returns and drop strobes on the falling edge
  task automatic tick();
    @(negedge Clk_CI);
    checkResponse();
    logTrigger = 1'b0;
    regWrEn    = 1'b0;
    regRdEn    = 1'b0;
  endtask

  task automatic doTrigger();
    for (int k = 0; k < WORDS - 1; k++) begin
      rngState = xorshift(rngState);
      logData[k*32 +: 32] = rngState;
    end
    logTrigger = 1'b1;
    // Stored only when enabled and not full
    if (modelEnable && modelCount < NUM_ENTRIES) begin
      modelMem[modelCount][0] = cycle;
      for (int k = 1; k < WORDS; k++) begin
        modelMem[modelCount][k] = logData[(k-1)*32 +: 32];
      end
      modelCount++;
    end
  endtask

  task automatic doRead(input stepT s);
    readT rec;
    int   wordIdx;
    regAddr    = s.addr;
    regRdEn    = 1'b1;
    rec.issued = cycle;
    rec.rdy    = ready;
    rec.af     = almostFull;
    rec.exp    = s.val;
    rec.kind   = (s.addr == EventLogPkg::REG_STATUS) ? R_STATUS : R_REG;
    if (s.kind == K_LOG) begin
      // Upper bits pick the entry and low bits the word
      wordIdx  = int'(s.addr[IDX_BITS+SEL_BITS-1:0]);
      rec.kind = R_LOG;
      rec.exp  = modelMem[wordIdx / WORDS][wordIdx % WORDS];
    end
    pending.push_back(rec);
  endtask

  task automatic doWrite(input stepT s);
    logic [31:0] busy;
    regAddr   = s.addr;
    regWrData = s.val;
    regWrEn   = 1'b1;
    if (s.addr == EventLogPkg::REG_CTRL) begin
      modelEnable = s.val[0];
      if (s.val[1]) begin
        // Pulse at the write edge, sweep from the edge after
        busy = '0;
        tick();
        tick();
        // Count the cycles with ready low
        while (!ready) begin
          busy = busy + 1'b1;
          tick();
        end
        checkWord("clear busy cycles", busy, 32'(NUM_ENTRIES));
        modelCount = 0;
        foreach (modelMem[i, j]) modelMem[i][j] = '0;
      end
    end
  endtask

  task automatic buildTable();
    // Values after reset
    addStep(K_RD, EventLogPkg::REG_STATUS, statusWord(1'b1, 1'b0, 1'b0));
    addStep(K_RD, EventLogPkg::REG_COUNT, 32'd0);
    addStep(K_RD, EventLogPkg::REG_MARGIN, 32'd4);
    addStep(K_RD, EventLogPkg::REG_CTRL, 32'd0);
    // Triggers dropped while disabled
    repeat (3) addStep(K_TRIG, '0, '0);
    addStep(K_RD, EventLogPkg::REG_COUNT, 32'd0);
    addStep(K_WR, EventLogPkg::REG_CTRL, 32'd1);
    addStep(K_RD, EventLogPkg::REG_CTRL, 32'd1);
    addStep(K_TRIG, '0, '0);
    addStep(K_IDLE, '0, '0);
    addStep(K_TRIG, '0, '0);
    addStep(K_TRIG, '0, '0);
    addStep(K_RD, EventLogPkg::REG_COUNT, 32'd3);
    // Back-to-back window reads of three entries
    for (int e = 0; e < 3; e++) begin
      for (int w = 0; w < WORDS; w++) addStep(K_LOG, logAddr(e, w), '0);
    end
    // Back-to-back register reads
    addStep(K_RD, EventLogPkg::REG_COUNT, 32'd3);
    addStep(K_RD, EventLogPkg::REG_MARGIN, 32'd4);
    addStep(K_RD, EventLogPkg::REG_STATUS, statusWord(1'b1, 1'b0, 1'b0));
    // Margin 6 gives almost full from 10 entries
    addStep(K_WR, EventLogPkg::REG_MARGIN, 32'd6);
    addStep(K_RD, EventLogPkg::REG_MARGIN, 32'd6);
    repeat (6) addStep(K_TRIG, '0, '0);
    addStep(K_RD, EventLogPkg::REG_STATUS, statusWord(1'b1, 1'b0, 1'b0));
    addStep(K_TRIG, '0, '0);
    addStep(K_RD, EventLogPkg::REG_STATUS, statusWord(1'b1, 1'b0, 1'b1));
    addStep(K_RD, EventLogPkg::REG_COUNT, 32'd10);
    repeat (5) addStep(K_TRIG, '0, '0);
    addStep(K_RD, EventLogPkg::REG_STATUS, statusWord(1'b1, 1'b0, 1'b1));
    addStep(K_TRIG, '0, '0);
    // Full with ready low and triggers ignored
    addStep(K_RD, EventLogPkg::REG_STATUS, statusWord(1'b0, 1'b1, 1'b1));
    repeat (2) addStep(K_TRIG, '0, '0);
    addStep(K_RD, EventLogPkg::REG_COUNT, 32'd16);
    addStep(K_LOG, logAddr(15, 0), '0);
    addStep(K_LOG, logAddr(15, 3), '0);
    addStep(K_LOG, logAddr(9, 2), '0);
    // Clear with enable kept
    addStep(K_WR, EventLogPkg::REG_CTRL, 32'd3);
    addStep(K_RD, EventLogPkg::REG_COUNT, 32'd0);
    addStep(K_RD, EventLogPkg::REG_STATUS, statusWord(1'b1, 1'b0, 1'b0));
    addStep(K_RD, EventLogPkg::REG_CTRL, 32'd1);
    for (int w = 0; w < WORDS; w++) addStep(K_LOG, logAddr(0, w), '0);
    addStep(K_LOG, logAddr(15, 1), '0);
    // Logging restarts at entry 0
    addStep(K_TRIG, '0, '0);
    addStep(K_TRIG, '0, '0);
    addStep(K_RD, EventLogPkg::REG_COUNT, 32'd2);
    for (int w = 0; w < WORDS; w++) addStep(K_LOG, logAddr(0, w), '0);
    addStep(K_LOG, logAddr(1, 0), '0);
    addStep(K_LOG, logAddr(1, 3), '0);
  endtask

  initial begin
    Clk_CI      = 1'b0;
    rstN        = 1'b0;
    logData     = '0;
    logTrigger  = 1'b0;
    regAddr     = '0;
    regWrEn     = 1'b0;
    regWrData   = '0;
    regRdEn     = 1'b0;
    rngState    = 32'ha4996d42;
    modelEnable = 1'b0;
    modelCount  = 0;
    buildTable();
    repeat (8) @(posedge Clk_CI);
    @(negedge Clk_CI);
    rstN = 1'b1;
    foreach (steps[i]) begin
      // Register read must not meet a window result in the same cycle
      if (steps[i].kind == K_RD) begin
        while (logReadsPending()) tick();
      end
      tick();
      case (steps[i].kind)
        K_TRIG:      doTrigger();
        K_WR:        doWrite(steps[i]);
        K_RD, K_LOG: doRead(steps[i]);
        default:     ;
      endcase
    end
    // Last reads still in flight
    while (pending.size() != 0) tick();
    $display("Test completed successfully");
    $finish;
  end

  // Limit scales with the table length
  initial begin
    @(posedge rstN);
    repeat (steps.size() * 8 + NUM_ENTRIES + 50) @(posedge Clk_CI);
    abortRun($sformatf("Watchdog expired after %0d cycles, the test did not finish",
                       steps.size() * 8 + NUM_ENTRIES + 50));
  end

endmodule

// ==== eventLog.f ====
hdl/EventLogPkg.sv
hdl/LogRam.sv
hdl/LogWordReader.sv
hdl/LogCtrl.sv
hdl/LogRegs.sv
hdl/EventLogTop.sv
test/EventLogTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the eventLog testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary -j 0 --top-module EventLogTb -f eventLog.f

# A failing run exits nonzero, the log decides the result
./obj_dir/VEventLogTb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
  echo "Simulation ended without a pass line"
  exit 1
fi
